//--- source/afu_pkg.sv
/* Shared widths, beat and descriptor types for the memory copy kernel.
   Every RTL module takes these through a wildcard import. */
package afu_pkg;

  // ------------------------------------------------------------
  // Widths
  // ------------------------------------------------------------
  localparam int ADDR_W        = 64;  // AXI address
  localparam int DATA_W        = 64;  // One beat, 8 bytes
  localparam int LEN_W         = 8;   // AXI burst length field
  localparam int STAGE_CREDITS = 2;   // Write engine staging entries

  typedef logic [ADDR_W-1:0] addr_t;

  // One data beat, seen as bytes or as 32-bit lanes
  typedef union packed {
    logic [DATA_W/8-1:0][7:0]   bytes;
    logic [DATA_W/32-1:0][31:0] lanes;
  } beat_u;

  // Captured host descriptor
  typedef struct packed {
    addr_t       src;         // Read burst base
    addr_t       dst;         // Write burst base
    logic [31:0] count;       // Beats, 1 to 256
    logic        swap_read;   // Lane swap on rdata
    logic        swap_write;  // Lane swap on wdata
  } descriptor_t;

  // Reverse byte order inside each 32-bit lane when enabled
  function automatic beat_u swap_lanes(input beat_u beat, input logic enable);
    beat_u swapped;
    swapped = beat;
    if (enable) begin
      for (int l = 0; l < DATA_W/32; l++) begin
        for (int b = 0; b < 4; b++) begin
          swapped.bytes[4*l + b] = beat.lanes[l][8*(3-b) +: 8];  // Byte b takes byte 3-b
        end
      end
    end
    return swapped;
  endfunction

endpackage

//--- source/afu_stream_if.sv
/* Credit-controlled beat link between two pipeline stages.
   The sender spends one credit per valid cycle, the receiver pulses credit per freed entry. */
`timescale 1ns/1ps

interface afu_stream_if import afu_pkg::*; ();

  logic  valid;   // Beat present this cycle
  beat_u beat;    // Payload
  logic  last;    // Final beat of the burst
  logic  credit;  // One entry freed downstream

  // Sending side
  modport producer (
    output valid,
    output beat,
    output last,
    input  credit
  );

  // Receiving side
  modport consumer (
    input  valid,
    input  beat,
    input  last,
    output credit
  );

endinterface

//--- source/afu_control.sv
/* Kernel control. Stretches the reset, runs the ap_ctrl_chain handshake
   and captures the descriptor words on start. */
`timescale 1ns/1ps

module afu_control import afu_pkg::*; #(
  parameter int RESET_HOLD = 16
) (
  input  logic        ap_clk,
  input  logic        ap_rst_n,
  input  logic        ap_start,
  input  logic        ap_continue,
  input  logic [63:0] buffer_0,
  input  logic [63:0] buffer_1,
  input  logic [63:0] buffer_2,
  input  logic [63:0] buffer_3,
  input  logic        done,       // Write response accepted
  output logic        core_rst,   // Stretched reset for the datapath
  output logic        go,         // One-cycle run pulse
  output descriptor_t desc,
  output logic        ap_idle,
  output logic        ap_done,
  output logic        ap_ready
);

  typedef enum logic [1:0] {
    S_IDLE,
    S_BUSY,
    S_DONE,   // Holding ap_done for ap_continue
    S_REARM   // Waiting out the stretched reset
  } state_e;

  state_e                state;
  logic [RESET_HOLD-1:0] hold_sr;   // Ones shift out one per cycle
  logic                  start_ok;
  logic                  done_ack;

  assign start_ok = (state == S_IDLE) && ap_start && !core_rst;
  assign done_ack = (state == S_DONE) && ap_continue;  // Host took the result

  // ------------------------------------------------------------
  // Reset stretcher
  // ------------------------------------------------------------
  always_ff @(posedge ap_clk or negedge ap_rst_n) begin
    if (!ap_rst_n) begin
      hold_sr <= '1;               // Assert at once
    end else if (done_ack) begin
      hold_sr <= '1;               // Re-arm for the next run
    end else begin
      hold_sr <= hold_sr << 1;
    end
  end

  assign core_rst = hold_sr[RESET_HOLD-1];  // Drops RESET_HOLD edges after load

  // ------------------------------------------------------------
  // ap_ctrl_chain FSM
  // ------------------------------------------------------------
  always_ff @(posedge ap_clk or negedge ap_rst_n) begin
    if (!ap_rst_n) begin
      state    <= S_IDLE;
      go       <= 1'b0;
      ap_ready <= 1'b0;
    end else begin
      go       <= start_ok;          // Registered start
      ap_ready <= 1'b0;
      case (state)
        S_IDLE:  if (start_ok) state <= S_BUSY;
        S_BUSY: begin
          if (done) begin
            state    <= S_DONE;
            ap_ready <= 1'b1;        // Pulses with the rise of ap_done
          end
        end
        S_DONE:  if (ap_continue) state <= S_REARM;
        S_REARM: if (!core_rst) state <= S_IDLE;
        default: state <= S_IDLE;
      endcase
    end
  end

  assign ap_idle = (state == S_IDLE);
  assign ap_done = (state == S_DONE);

  // Descriptor words, stable for the whole run
  always_ff @(posedge ap_clk) begin
    if (start_ok) begin
      desc.src        <= buffer_0;
      desc.dst        <= buffer_1;
      desc.count      <= buffer_2[31:0];
      desc.swap_read  <= buffer_3[0];
      desc.swap_write <= buffer_3[1];
    end
  end

endmodule

//--- source/afu_read_engine.sv
/* Read side of the copy. Issues one AXI read burst and pushes each beat,
   lane swapped on request, into the link while credits remain. */
`timescale 1ns/1ps

module afu_read_engine import afu_pkg::*; #(
  parameter int FIFO_DEPTH = 16
) (
  input  logic              ap_clk,
  input  logic              core_rst,
  input  logic              go,
  input  descriptor_t       desc,
  output logic              m00_axi_arvalid,
  input  logic              m00_axi_arready,
  output addr_t             m00_axi_araddr,
  output logic [LEN_W-1:0]  m00_axi_arlen,
  input  logic              m00_axi_rvalid,
  input  logic [DATA_W-1:0] m00_axi_rdata,
  input  logic              m00_axi_rlast,
  output logic              m00_axi_rready,
  afu_stream_if.producer    rd_link
);

  localparam int CRED_W = $clog2(FIFO_DEPTH + 1);

  logic [CRED_W-1:0] credits;   // Free FIFO entries as seen from here
  logic              rd_active; // Burst still owes beats
  logic              take;      // Beat accepted from memory
  beat_u             rd_word;

  // Address channel straight from the descriptor
  assign m00_axi_araddr = desc.src;
  assign m00_axi_arlen  = LEN_W'(desc.count - 32'd1);

  // Stall the memory once the FIFO view is full
  assign m00_axi_rready = rd_active && (credits != '0);
  assign take           = m00_axi_rvalid && m00_axi_rready;
  assign rd_word        = m00_axi_rdata;

  // ------------------------------------------------------------
  // Burst control
  // ------------------------------------------------------------
  always_ff @(posedge ap_clk or posedge core_rst) begin
    if (core_rst) begin
      m00_axi_arvalid <= 1'b0;
      rd_active       <= 1'b0;
    end else begin
      if (go) begin
        m00_axi_arvalid <= 1'b1;     // Rises the cycle after go
        rd_active       <= 1'b1;
      end else if (m00_axi_arready) begin
        m00_axi_arvalid <= 1'b0;
      end
      if (take && m00_axi_rlast) begin
        rd_active <= 1'b0;           // Whole burst received
      end
    end
  end

  // Credit count, spent per accepted beat, refilled per pop
  always_ff @(posedge ap_clk or posedge core_rst) begin
    if (core_rst) begin
      credits       <= CRED_W'(FIFO_DEPTH);
      rd_link.valid <= 1'b0;
    end else begin
      rd_link.valid <= take;
      case ({rd_link.credit, take})
        2'b10:   credits <= credits + 1'b1;
        2'b01:   credits <= credits - 1'b1;
        default: credits <= credits;   // None or both
      endcase
    end
  end

  // Beat payload
  always_ff @(posedge ap_clk) begin
    if (take) begin
      rd_link.beat <= swap_lanes(rd_word, desc.swap_read);
      rd_link.last <= m00_axi_rlast;
    end
  end

endmodule

//--- source/afu_credit_fifo.sv
/* Beat FIFO between the read and write engines. Hands one credit back upstream
   per pop and sends downstream only while it holds staging credits. */
`timescale 1ns/1ps

module afu_credit_fifo import afu_pkg::*; #(
  parameter int FIFO_DEPTH = 16
) (
  input  logic           ap_clk,
  input  logic           core_rst,
  afu_stream_if.consumer rd_link,
  afu_stream_if.producer wr_link
);

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);
  localparam int WCR_W = $clog2(STAGE_CREDITS + 1);

  beat_u             mem      [FIFO_DEPTH];
  logic              last_mem [FIFO_DEPTH];
  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;
  logic [CNT_W-1:0]  used;        // Entries held
  logic [WCR_W-1:0]  wr_credits;  // Free staging slots downstream
  logic              pop;

  // Wrap for any depth, not only powers of two
  function automatic logic [PTR_W-1:0] bump(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign pop = (used != '0) && (wr_credits != '0);

  // Storage, written by every pushed beat
  always_ff @(posedge ap_clk) begin
    if (rd_link.valid) begin
      mem[wr_ptr]      <= rd_link.beat;
      last_mem[wr_ptr] <= rd_link.last;
    end
    if (pop) begin
      wr_link.beat <= mem[rd_ptr];
      wr_link.last <= last_mem[rd_ptr];
    end
  end

  // ------------------------------------------------------------
  // Pointers and credits
  // ------------------------------------------------------------
  always_ff @(posedge ap_clk or posedge core_rst) begin
    if (core_rst) begin
      wr_ptr         <= '0;
      rd_ptr         <= '0;
      used           <= '0;
      wr_credits     <= WCR_W'(STAGE_CREDITS);
      wr_link.valid  <= 1'b0;
      rd_link.credit <= 1'b0;
    end else begin
      if (rd_link.valid) wr_ptr <= bump(wr_ptr);
      if (pop) rd_ptr <= bump(rd_ptr);
      used           <= used + CNT_W'(rd_link.valid) - CNT_W'(pop);
      wr_credits     <= wr_credits + WCR_W'(wr_link.credit) - WCR_W'(pop);
      wr_link.valid  <= pop;         // Leaves two cycles after push at best
      rd_link.credit <= pop;         // Entry freed upstream
    end
  end

endmodule

//--- source/afu_write_engine.sv
/* Write side of the copy. Issues one AXI write burst, drains a two-entry
   staging buffer onto W with optional lane swap, and flags done on B. */
`timescale 1ns/1ps

module afu_write_engine import afu_pkg::*; (
  input  logic              ap_clk,
  input  logic              core_rst,
  input  logic              go,
  input  descriptor_t       desc,
  output logic              m00_axi_awvalid,
  input  logic              m00_axi_awready,
  output addr_t             m00_axi_awaddr,
  output logic [LEN_W-1:0]  m00_axi_awlen,
  output logic              m00_axi_wvalid,
  input  logic              m00_axi_wready,
  output logic [DATA_W-1:0] m00_axi_wdata,
  output logic              m00_axi_wlast,
  input  logic              m00_axi_bvalid,
  output logic              m00_axi_bready,
  afu_stream_if.consumer    wr_link,
  output logic              done
);

  beat_u            stage_q [STAGE_CREDITS];  // Staging slots
  logic             head;                     // Next slot to send
  logic             tail;                     // Next slot to fill
  logic [1:0]       fill;                     // 0 to 2 beats held
  logic [LEN_W-1:0] sent;                     // Beats accepted on W
  logic             push;
  logic             pop;

  assign m00_axi_awaddr = desc.dst;
  assign m00_axi_awlen  = LEN_W'(desc.count - 32'd1);

  // ------------------------------------------------------------
  // W channel
  // ------------------------------------------------------------
  assign push           = wr_link.valid;      // Space assured by credits
  assign m00_axi_wvalid = (fill != 2'd0);     // Held until wready
  assign pop            = m00_axi_wvalid && m00_axi_wready;
  assign m00_axi_wdata  = swap_lanes(stage_q[head], desc.swap_write);
  assign m00_axi_wlast  = (sent == m00_axi_awlen);  // By beat count

  assign done = m00_axi_bvalid && m00_axi_bready;   // Response taken

  always_ff @(posedge ap_clk) begin
    if (push) begin
      stage_q[tail] <= wr_link.beat;
    end
  end

  always_ff @(posedge ap_clk or posedge core_rst) begin
    if (core_rst) begin
      head           <= 1'b0;
      tail           <= 1'b0;
      fill           <= 2'd0;
      wr_link.credit <= 1'b0;
    end else begin
      if (push) tail <= ~tail;
      if (pop) head <= ~head;
      fill           <= fill + 2'(push) - 2'(pop);
      wr_link.credit <= pop;         // Slot freed, credit back to FIFO
    end
  end

  // ------------------------------------------------------------
  // AW and B channels, beat count
  // ------------------------------------------------------------
  always_ff @(posedge ap_clk or posedge core_rst) begin
    if (core_rst) begin
      m00_axi_awvalid <= 1'b0;
      m00_axi_bready  <= 1'b0;
      sent            <= '0;
    end else begin
      if (go) begin
        m00_axi_awvalid <= 1'b1;     // Rises the cycle after go
        sent            <= '0;
      end else begin
        if (m00_axi_awready) m00_axi_awvalid <= 1'b0;
        if (pop) sent <= sent + 1'b1;
      end
      if (pop && m00_axi_wlast) begin
        m00_axi_bready <= 1'b1;      // Last beat out, wait for B
      end else if (m00_axi_bvalid) begin
        m00_axi_bready <= 1'b0;
      end
    end
  end

endmodule

//--- source/kernel_afu.sv
/* Top level of the memory copy kernel. Plain AXI and control ports,
   wiring control, read engine, credit FIFO and write engine. */
`timescale 1ns/1ps

module kernel_afu import afu_pkg::*; #(
  parameter int FIFO_DEPTH = 16,
  parameter int RESET_HOLD = 16
) (
  input  logic              ap_clk,
  input  logic              ap_rst_n,
  input  logic              ap_start,
  input  logic              ap_continue,
  output logic              ap_idle,
  output logic              ap_done,
  output logic              ap_ready,
  input  logic [63:0]       buffer_0,   // Source address
  input  logic [63:0]       buffer_1,   // Destination address
  input  logic [63:0]       buffer_2,   // Beat count
  input  logic [63:0]       buffer_3,   // Swap flags
  output logic              m00_axi_arvalid,
  input  logic              m00_axi_arready,
  output logic [ADDR_W-1:0] m00_axi_araddr,
  output logic [LEN_W-1:0]  m00_axi_arlen,
  input  logic              m00_axi_rvalid,
  input  logic [DATA_W-1:0] m00_axi_rdata,
  input  logic              m00_axi_rlast,
  output logic              m00_axi_rready,
  output logic              m00_axi_awvalid,
  output logic [ADDR_W-1:0] m00_axi_awaddr,
  output logic [LEN_W-1:0]  m00_axi_awlen,
  input  logic              m00_axi_awready,
  output logic              m00_axi_wvalid,
  output logic [DATA_W-1:0] m00_axi_wdata,
  output logic              m00_axi_wlast,
  input  logic              m00_axi_wready,
  input  logic              m00_axi_bvalid,
  output logic              m00_axi_bready
);

  logic        core_rst;
  logic        go;
  logic        done;
  descriptor_t desc;

  afu_stream_if rd_link ();   // Read engine to FIFO
  afu_stream_if wr_link ();   // FIFO to write engine

  afu_control #(.RESET_HOLD(RESET_HOLD)) control_i (
    .ap_clk, .ap_rst_n, .ap_start, .ap_continue,
    .buffer_0, .buffer_1, .buffer_2, .buffer_3,
    .done, .core_rst, .go, .desc,
    .ap_idle, .ap_done, .ap_ready
  );

  afu_read_engine #(.FIFO_DEPTH(FIFO_DEPTH)) read_i (
    .ap_clk, .core_rst, .go, .desc,
    .m00_axi_arvalid, .m00_axi_arready, .m00_axi_araddr, .m00_axi_arlen,
    .m00_axi_rvalid, .m00_axi_rdata, .m00_axi_rlast, .m00_axi_rready,
    .rd_link(rd_link.producer)
  );

  afu_credit_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) fifo_i (
    .ap_clk, .core_rst,
    .rd_link(rd_link.consumer),
    .wr_link(wr_link.producer)
  );

  afu_write_engine write_i (
    .ap_clk, .core_rst, .go, .desc,
    .m00_axi_awvalid, .m00_axi_awready, .m00_axi_awaddr, .m00_axi_awlen,
    .m00_axi_wvalid, .m00_axi_wready, .m00_axi_wdata, .m00_axi_wlast,
    .m00_axi_bvalid, .m00_axi_bready,
    .wr_link(wr_link.consumer),
    .done
  );

endmodule

//--- sim/kernel_afu_sva.sv
/* Handshake assertions for the memory copy kernel, bound onto kernel_afu.
   Each failing property raises $error and bumps a count that the testbench polls. */
`timescale 1ns/1ps

module kernel_afu_sva (
  input logic ap_clk,
  input logic ap_rst_n,
  input logic core_rst,
  input logic ap_done,
  input logic ap_continue,
  input logic arvalid,
  input logic arready,
  input logic awvalid,
  input logic awready,
  input logic wvalid,
  input logic wready,
  input logic rready
);

  int unsigned violations = 0;  // Failed properties so far

  // ------------------------------------------------------------
  // AXI valid stays up until the transfer
  // ------------------------------------------------------------
  ar_hold: assert property (@(posedge ap_clk) disable iff (!ap_rst_n)
    arvalid && !arready |=> arvalid)
    else begin violations++; $error("arvalid dropped before arready"); end

  aw_hold: assert property (@(posedge ap_clk) disable iff (!ap_rst_n)
    awvalid && !awready |=> awvalid)
    else begin violations++; $error("awvalid dropped before awready"); end

  w_hold: assert property (@(posedge ap_clk) disable iff (!ap_rst_n)
    wvalid && !wready |=> wvalid)
    else begin violations++; $error("wvalid dropped before wready"); end

  // Host handshake and stretched reset
  done_hold: assert property (@(posedge ap_clk) disable iff (!ap_rst_n)
    ap_done && !ap_continue |=> ap_done)
    else begin violations++; $error("ap_done fell without ap_continue"); end

  no_read_in_reset: assert property (@(posedge ap_clk) disable iff (!ap_rst_n)
    core_rst |-> !rready)
    else begin violations++; $error("rready high during core reset"); end

endmodule

bind kernel_afu kernel_afu_sva sva_i (
  .ap_clk, .ap_rst_n, .core_rst, .ap_done, .ap_continue,
  .arvalid(m00_axi_arvalid), .arready(m00_axi_arready),
  .awvalid(m00_axi_awvalid), .awready(m00_axi_awready),
  .wvalid(m00_axi_wvalid), .wready(m00_axi_wready),
  .rready(m00_axi_rready)
);

//--- sim/tb_kernel_afu.sv
/* Testbench for the memory copy kernel. An AXI memory model serves the read burst
   and captures the write burst, directed tests compare each copy with its source. */
`timescale 1ns/1ps

module tb_kernel_afu import afu_pkg::*; ();

  localparam int RESET_HOLD     = 16;
  localparam int RUNS           = 7;
  localparam int TOTAL_BEATS    = 8 + 16 + 16 + 16 + 64 + 12 + 12;
  localparam int RUN_SLACK      = 24;  // Start, pipeline fill, B response
  localparam int TIMEOUT_CYCLES =
    (3 + RESET_HOLD + TOTAL_BEATS + 20 + RUNS * (RUN_SLACK + RESET_HOLD)) * 4;

  logic ap_clk = 1'b0;
  logic ap_rst_n = 1'b0;
  logic ap_start = 1'b0;
  logic ap_continue = 1'b0;
  logic ap_idle, ap_done, ap_ready;
  logic [63:0] buffer_0 = '0, buffer_1 = '0, buffer_2 = '0, buffer_3 = '0;
  logic m00_axi_arvalid, m00_axi_rready, m00_axi_awvalid, m00_axi_wvalid, m00_axi_wlast;
  logic m00_axi_bready;
  logic [ADDR_W-1:0] m00_axi_araddr, m00_axi_awaddr;
  logic [LEN_W-1:0]  m00_axi_arlen, m00_axi_awlen;
  logic [DATA_W-1:0] m00_axi_wdata;
  logic m00_axi_arready = 1'b0;
  logic m00_axi_awready = 1'b0;
  logic m00_axi_wready = 1'b0;
  logic m00_axi_rvalid = 1'b0;
  logic m00_axi_rlast = 1'b0;
  logic m00_axi_bvalid = 1'b0;
  logic [DATA_W-1:0] m00_axi_rdata = '0;

  logic [DATA_W-1:0] mem [0:1023];  // 8 KB of 64-bit words
  string test_name = "reset";
  logic  backpressure = 1'b0;       // Random gaps on the AXI side
  int    cycles = 0;
  int    rd_base = 0, rd_total = 0, rd_cnt = 0;
  int    wr_base = 0, wr_total = 0, wr_cnt = 0;
  logic  wr_open = 1'b0;            // AW taken, W beats owed
  logic  b_pend = 1'b0;
  addr_t exp_src = '0;              // Descriptor of the run in progress
  addr_t exp_dst = '0;
  int    exp_count = 0;

  kernel_afu #(.FIFO_DEPTH(16), .RESET_HOLD(RESET_HOLD)) dut_i (.*);

  always #20 ap_clk = ~ap_clk;

  // ------------------------------------------------------------
  // Failure handling and compares
  // ------------------------------------------------------------
  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1, "run stopped at the first failure");
  endtask

  task automatic check_beat(input string what, input beat_u expected, input beat_u actual);
    if (actual !== expected)
      abort_run($sformatf("error %s: %s expected %h actual %h",
                          test_name, what, expected, actual));
  endtask

  task automatic check_flag(input string what, input logic expected, input logic actual);
    if (actual !== expected)
      abort_run($sformatf("error %s: %s expected %b actual %b",
                          test_name, what, expected, actual));
  endtask

  task automatic check_addr(input string what, input addr_t expected, input addr_t actual);
    if (actual !== expected)
      abort_run($sformatf("error %s: %s expected %h actual %h",
                          test_name, what, expected, actual));
  endtask

  task automatic check_len(input string what, input logic [LEN_W-1:0] expected,
                           input logic [LEN_W-1:0] actual);
    if (actual !== expected)
      abort_run($sformatf("error %s: %s expected %0d actual %0d",
                          test_name, what, expected, actual));
  endtask

  function automatic logic random_gap();
    return backpressure && ($urandom % 4 == 0);  // One cycle in four
  endfunction

  // Reference lane swap, byte by byte
  function automatic beat_u lane_reverse(input logic [63:0] w);
    return {w[39:32], w[47:40], w[55:48], w[63:56], w[7:0], w[15:8], w[23:16], w[31:24]};
  endfunction

  // ------------------------------------------------------------
  // AXI memory model
  // ------------------------------------------------------------
  always @(posedge ap_clk) begin
    if (m00_axi_arvalid && m00_axi_arready) begin
      check_addr("araddr", exp_src, m00_axi_araddr);
      check_len("arlen", LEN_W'(exp_count - 1), m00_axi_arlen);
      rd_base  = int'(m00_axi_araddr[12:3]);
      rd_total = int'(m00_axi_arlen) + 1;
      rd_cnt   = 0;
    end
    if (m00_axi_awvalid && m00_axi_awready) begin
      check_addr("awaddr", exp_dst, m00_axi_awaddr);
      check_len("awlen", LEN_W'(exp_count - 1), m00_axi_awlen);
      wr_base  = int'(m00_axi_awaddr[12:3]);
      wr_total = int'(m00_axi_awlen) + 1;
      wr_cnt   = 0;
      wr_open  = 1'b1;
    end
    if (m00_axi_rvalid && m00_axi_rready) rd_cnt++;
    if (!m00_axi_rvalid || m00_axi_rready) begin     // Slot free for next beat
      if (rd_cnt < rd_total && !random_gap()) begin
        m00_axi_rvalid <= 1'b1;
        m00_axi_rdata  <= mem[rd_base + rd_cnt];
        m00_axi_rlast  <= (rd_cnt == rd_total - 1);
      end else begin
        m00_axi_rvalid <= 1'b0;
      end
    end
    if (m00_axi_wvalid && m00_axi_wready) begin
      mem[wr_base + wr_cnt] = m00_axi_wdata;
      check_flag("wlast", wr_cnt == exp_count - 1, m00_axi_wlast);
      wr_cnt++;
      if (wr_cnt == wr_total) begin
        wr_open = 1'b0;
        b_pend  = 1'b1;                              // Respond next cycle
      end
    end
    if (m00_axi_bvalid && m00_axi_bready) begin
      m00_axi_bvalid <= 1'b0;
    end else if (b_pend) begin
      m00_axi_bvalid <= 1'b1;
      b_pend = 1'b0;
    end
    m00_axi_arready <= !random_gap();
    m00_axi_awready <= !random_gap();
    m00_axi_wready  <= wr_open && !random_gap();
  end

  // Watchdog and assertion monitor
  always @(posedge ap_clk) begin
    cycles++;
    if (dut_i.sva_i.violations != 0)
      abort_run("a handshake assertion on kernel_afu failed");
    else if (cycles > TIMEOUT_CYCLES)
      abort_run($sformatf("timeout, the kernel did not finish within %0d cycles", cycles));
  end

  // ------------------------------------------------------------
  // Directed tests
  // ------------------------------------------------------------
  task automatic check_reset_state();
    check_flag("ap_idle", 1'b1, ap_idle);
    check_flag("ap_done", 1'b0, ap_done);
    check_flag("ap_ready", 1'b0, ap_ready);
    check_flag("arvalid", 1'b0, m00_axi_arvalid);
    check_flag("awvalid", 1'b0, m00_axi_awvalid);
    check_flag("wvalid", 1'b0, m00_axi_wvalid);
    check_flag("rready", 1'b0, m00_axi_rready);
    check_flag("bready", 1'b0, m00_axi_bready);
  endtask

  // One full copy: fill source, start, handshake, compare destination
  task automatic run_copy(input logic [63:0] src, input logic [63:0] dst, input int count,
                          input logic [1:0] flags, input int hold_cycles);
    int          s;
    int          d;
    logic [63:0] src_word;
    beat_u       expected;
    s = int'(src[12:3]);
    d = int'(dst[12:3]);
    exp_src   = src;
    exp_dst   = dst;
    exp_count = count;
    for (int i = 0; i < count; i++) mem[s + i] = {$urandom, $urandom};
    @(posedge ap_clk);
    buffer_0 <= src;
    buffer_1 <= dst;
    buffer_2 <= 64'(count);
    buffer_3 <= 64'(flags);                          // Bit 0 read swap, bit 1 write swap
    ap_start <= 1'b1;
    do @(posedge ap_clk); while (!ap_ready);
    check_flag("ap_done with ap_ready", 1'b1, ap_done);
    ap_start <= 1'b0;
    repeat (hold_cycles) begin
      @(posedge ap_clk);
      check_flag("ap_done while held", 1'b1, ap_done);
      check_flag("ap_idle while held", 1'b0, ap_idle);
    end
    ap_continue <= 1'b1;
    @(posedge ap_clk);
    check_flag("ap_ready after its pulse", 1'b0, ap_ready);
    ap_continue <= 1'b0;
    @(posedge ap_clk);
    check_flag("ap_done after continue", 1'b0, ap_done);
    while (!ap_idle) @(posedge ap_clk);             // Stretched reset released
    for (int i = 0; i < count; i++) begin
      src_word = mem[s + i];
      if (flags[0] ^ flags[1]) expected = lane_reverse(src_word);
      else expected = src_word;                      // Two swaps cancel
      check_beat($sformatf("beat %0d", i), expected, mem[d + i]);
    end
  endtask

  task automatic test_plain_copy();
    test_name = "plain_copy";
    run_copy(64'h0000, 64'h1000, 8, 2'b00, 0);
  endtask

  task automatic test_read_swap();
    test_name = "read_swap";
    run_copy(64'h0100, 64'h1100, 16, 2'b01, 0);
  endtask

  task automatic test_write_swap();
    test_name = "write_swap";
    run_copy(64'h0200, 64'h1200, 16, 2'b10, 0);
    test_name = "both_swaps";
    run_copy(64'h0300, 64'h1300, 16, 2'b11, 0);
  endtask

  task automatic test_backpressure();
    test_name = "backpressure";
    backpressure <= 1'b1;
    run_copy(64'h0400, 64'h1400, 64, 2'b00, 0);
    backpressure <= 1'b0;
  endtask

  task automatic test_continue_hold();
    test_name = "continue_hold";
    run_copy(64'h0600, 64'h1600, 12, 2'b01, 20);
    test_name = "second_run";
    run_copy(64'h0700, 64'h1700, 12, 2'b10, 0);
  endtask

  initial begin
    void'($urandom(32'heb04));
    for (int i = 0; i < 1024; i++) mem[i] = {32'hC0DE_0000 | 32'(i), ~(32'(i) << 3)};
    repeat (3) @(posedge ap_clk);
    ap_rst_n <= 1'b1;
    @(posedge ap_clk);
    check_reset_state();
    test_plain_copy();
    test_read_swap();
    test_write_swap();
    test_backpressure();
    test_continue_hold();
    if (dut_i.sva_i.violations != 0) begin
      abort_run("a handshake assertion on kernel_afu failed");
    end else begin
      $display("TEST PASSED");
      $finish;
    end
  end

endmodule

//--- build.f
source/afu_pkg.sv
source/afu_stream_if.sv
source/afu_control.sv
source/afu_read_engine.sv
source/afu_credit_fifo.sv
source/afu_write_engine.sv
source/kernel_afu.sv
sim/kernel_afu_sva.sv
sim/tb_kernel_afu.sv

//--- Makefile
# Verilator build and run for the memory copy kernel testbench
VERILATOR ?= verilator
TOP       ?= tb_kernel_afu
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --assert -Wno-fatal -j 0
RUN_ARGS  ?= +verilator+error+limit+100
PASS_TEXT ?= TEST PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
